// ==== verilog/sram_match_pkg.sv ====
`default_nettype none

package sram_match_pkg;

    typedef logic [1:0]  port_idx_t;   // Switch port, also used as destination
    typedef logic [2:0]  sram_idx_t;   // Bank in the shared pool
    typedef logic [8:0]  pkt_len_t;    // Packet length in half-words
    typedef logic [10:0] space_t;      // Bank free space in half-words
    typedef logic [8:0]  pkt_cnt_t;    // Packets per bank per destination
    typedef logic        match_mode_t;

    localparam match_mode_t MODE_STATIC  = 1'b0;  // Port p owns banks 2p and 2p+1
    localparam match_mode_t MODE_DYNAMIC = 1'b1;  // Whole pool open to every port

    localparam space_t SRAM_CAPACITY = 11'd1024;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SCAN,
        ST_DONE
    } match_state_t;

endpackage

`default_nettype wire

// ==== verilog/wr_request_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module wr_request_dispatch
    import sram_match_pkg::*;
#(
    parameter int NUM_PORTS = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req_valid,
    output logic                 req_ready,
    input  port_idx_t            req_port,
    input  port_idx_t            req_dest,
    input  pkt_len_t             req_length,
    input  logic [NUM_PORTS-1:0] done,
    output logic [NUM_PORTS-1:0] match_enable,
    output port_idx_t            match_dest [NUM_PORTS],
    output pkt_len_t             match_length [NUM_PORTS]
);

    logic ready_armed;  // Keeps req_ready low in the first cycle out of reset
    logic req_fire;

    assign req_ready = ready_armed && !match_enable[req_port];
    assign req_fire  = req_valid && req_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ready_armed <= 1'b0;
        end else begin
            ready_armed <= 1'b1;
        end
    end

    // One slot per port, held until that port's matcher reports done
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            match_enable <= '0;
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (req_fire && req_port == port_idx_t'(p)) begin
                    match_enable[p] <= 1'b1;
                end else if (done[p]) begin
                    match_enable[p] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (req_fire && req_port == port_idx_t'(p)) begin
                match_dest[p]   <= req_dest;
                match_length[p] <= req_length;
            end
        end
    end

    // A matcher may only finish work that was handed to it
    a_done_needs_slot: assert property (@(posedge clk) disable iff (!rst_n)
        (done & ~match_enable) == '0);

endmodule

`default_nettype wire

// ==== verilog/port_wr_sram_matcher.sv ====
`timescale 1ns/1ps
`default_nettype none

module port_wr_sram_matcher
    import sram_match_pkg::*;
#(
    parameter int PORT_IDX = 0
) (
    input  logic        clk,
    input  logic        rst_n,
    input  match_mode_t match_mode,
    input  logic [3:0]  match_threshold,
    input  logic        match_enable,
    input  port_idx_t   match_dest,
    input  pkt_len_t    match_length,
    input  space_t      bank_free,
    input  pkt_cnt_t    bank_count,
    input  logic        bank_accessible,
    input  logic        bound_valid,
    input  sram_idx_t   bound_sram,
    input  logic        res_ready,
    input  logic        res_reject,
    output sram_idx_t   scan_sram,
    output logic        res_valid,
    output sram_idx_t   res_sram,
    output logic        done
);

    match_state_t state;

    sram_idx_t  scan_ptr;
    sram_idx_t  next_ptr;
    sram_idx_t  base_sram;
    sram_idx_t  best_sram;
    sram_idx_t  next_best;
    pkt_cnt_t   best_cnt;
    logic [3:0] examined;
    logic [3:0] exam_next;
    logic       found;
    logic       fits;
    logic       cand;
    logic       take;
    logic       scan_end;
    logic       in_set;
    logic       fast_hit;
    port_idx_t  last_dest;    // Destination of the last consumed result
    logic       last_valid;

    // Table lookup follows the bank under test in each state
    always_comb begin
        case (state)
            ST_SCAN: scan_sram = scan_ptr;
            ST_DONE: scan_sram = res_sram;
            default: scan_sram = bound_sram;
        endcase
    end

    assign base_sram = (match_mode == MODE_DYNAMIC) ? '0 : sram_idx_t'(2 * PORT_IDX);
    assign next_ptr  = (match_mode == MODE_STATIC) ? {scan_ptr[2:1], ~scan_ptr[0]}
                                                   : scan_ptr + 1'b1;

    assign fits = bank_free >= space_t'(match_length);
    assign cand = bank_accessible && fits;

    // Strictly higher count only, so the first bank visited wins a tie
    assign take      = cand && (!found || bank_count > best_cnt);
    assign next_best = take ? scan_ptr : best_sram;
    assign exam_next = (examined == 4'hf) ? examined : examined + 4'd1;
    assign scan_end  = (found || cand) && exam_next >= match_threshold;

    // Sticky bank reused when the flow continues and the packet fits
    assign in_set   = match_mode == MODE_DYNAMIC || (bound_sram >> 1) == sram_idx_t'(PORT_IDX);
    assign fast_hit = bound_valid && in_set && last_valid && match_dest == last_dest && fits;

    // Offer is withdrawn if the bank filled up or was taken meanwhile
    assign res_valid = (state == ST_DONE) && cand;
    assign done      = res_valid && res_ready && !res_reject;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            last_valid <= 1'b0;
            found      <= 1'b0;
            examined   <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (match_enable) begin
                        if (fast_hit) begin
                            res_sram <= bound_sram;
                            state    <= ST_DONE;
                        end else begin
                            scan_ptr <= base_sram;
                            found    <= 1'b0;
                            examined <= '0;
                            state    <= ST_SCAN;
                        end
                    end
                end
                ST_SCAN: begin
                    scan_ptr <= next_ptr;        // One bank per cycle
                    examined <= exam_next;
                    found    <= found || cand;
                    if (take) begin
                        best_sram <= scan_ptr;
                        best_cnt  <= bank_count;
                    end
                    if (scan_end) begin
                        res_sram <= next_best;
                        state    <= ST_DONE;
                    end
                end
                ST_DONE: begin
                    if (done) begin
                        last_dest  <= match_dest;
                        last_valid <= 1'b1;
                        state      <= ST_IDLE;
                    end else if (!res_valid || (res_ready && res_reject)) begin
                        found    <= 1'b0;          // Lost the bank, search again
                        examined <= '0;
                        state    <= ST_SCAN;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    a_static_bank_set: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid && match_mode == MODE_STATIC |-> (res_sram >> 1) == sram_idx_t'(PORT_IDX));

endmodule

`default_nettype wire

// ==== verilog/sram_alloc_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_alloc_arbiter
    import sram_match_pkg::*;
#(
    parameter int NUM_PORTS = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [NUM_PORTS-1:0] res_valid,
    input  sram_idx_t            res_sram [NUM_PORTS],
    input  port_idx_t            match_dest [NUM_PORTS],
    input  pkt_len_t             match_length [NUM_PORTS],
    output logic [NUM_PORTS-1:0] res_ready,
    output logic [NUM_PORTS-1:0] res_reject,
    output logic                 grant_valid,
    output port_idx_t            grant_port,
    output sram_idx_t            grant_sram,
    output port_idx_t            grant_dest,
    output pkt_len_t             grant_length
);

    port_idx_t rr_ptr;     // Highest priority port this cycle
    port_idx_t win_port;
    logic      win_found;

    // First valid result at or after the pointer
    always_comb begin
        int idx;
        win_found = 1'b0;
        win_port  = '0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            idx = (int'(rr_ptr) + i) % NUM_PORTS;
            if (!win_found && res_valid[idx]) begin
                win_found = 1'b1;
                win_port  = port_idx_t'(idx);
            end
        end
    end

    assign grant_valid  = win_found;
    assign grant_port   = win_port;
    assign grant_sram   = res_sram[win_port];
    assign grant_dest   = match_dest[win_port];
    assign grant_length = match_length[win_port];

    // Losers aiming at the winner's bank are turned away now
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            res_ready[p]  = win_found && res_valid[p] &&
                            (port_idx_t'(p) == win_port || res_sram[p] == grant_sram);
            res_reject[p] = res_ready[p] && port_idx_t'(p) != win_port;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rr_ptr <= '0;
        end else if (win_found) begin
            rr_ptr <= (int'(win_port) == NUM_PORTS - 1) ? port_idx_t'(0) : win_port + 1'b1;
        end
    end

    // The winner's matcher consumes its result, so one result is granted only once
    a_grant_consumed: assert property (@(posedge clk) disable iff (!rst_n)
        grant_valid |=> !res_valid[$past(grant_port)]);

endmodule

`default_nettype wire

// ==== verilog/sram_state_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_state_table
    import sram_match_pkg::*;
#(
    parameter int NUM_PORTS = 4,
    parameter int NUM_SRAM  = 8
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  sram_idx_t            scan_sram [NUM_PORTS],
    input  port_idx_t            scan_dest [NUM_PORTS],
    input  logic                 grant_valid,
    input  port_idx_t            grant_port,
    input  sram_idx_t            grant_sram,
    input  port_idx_t            grant_dest,
    input  pkt_len_t             grant_length,
    input  logic                 rel_valid,
    input  port_idx_t            rel_port,
    input  logic                 deq_valid,
    input  sram_idx_t            deq_sram,
    input  port_idx_t            deq_dest,
    input  pkt_len_t             deq_length,
    output space_t               bank_free [NUM_PORTS],
    output pkt_cnt_t             bank_count [NUM_PORTS],
    output logic [NUM_PORTS-1:0] bank_accessible,
    output logic [NUM_PORTS-1:0] bound_valid,
    output sram_idx_t            bound_sram [NUM_PORTS]
);

    space_t   free_space [NUM_SRAM];
    pkt_cnt_t pkt_count  [NUM_SRAM][NUM_PORTS];  // Indexed by bank, then destination

    // Lookup port per matcher, a bank bound elsewhere is off limits
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            bank_free[p]       = free_space[scan_sram[p]];
            bank_count[p]      = pkt_count[scan_sram[p]][scan_dest[p]];
            bank_accessible[p] = 1'b1;
            for (int q = 0; q < NUM_PORTS; q++) begin
                if (q != p && bound_valid[q] && bound_sram[q] == scan_sram[p]) begin
                    bank_accessible[p] = 1'b0;
                end
            end
        end
    end

    // Grant and dequeue on the same bank both take effect
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int b = 0; b < NUM_SRAM; b++) begin
                free_space[b] <= SRAM_CAPACITY;
                for (int d = 0; d < NUM_PORTS; d++) begin
                    pkt_count[b][d] <= '0;
                end
            end
        end else begin
            for (int b = 0; b < NUM_SRAM; b++) begin
                free_space[b] <= free_space[b]
                    - ((grant_valid && grant_sram == sram_idx_t'(b)) ? space_t'(grant_length) : '0)
                    + ((deq_valid && deq_sram == sram_idx_t'(b)) ? space_t'(deq_length) : '0);
                for (int d = 0; d < NUM_PORTS; d++) begin
                    pkt_count[b][d] <= pkt_count[b][d]
                        + ((grant_valid && grant_sram == sram_idx_t'(b) &&
                            grant_dest == port_idx_t'(d)) ? pkt_cnt_t'(1) : '0)
                        - ((deq_valid && deq_sram == sram_idx_t'(b) &&
                            deq_dest == port_idx_t'(d)) ? pkt_cnt_t'(1) : '0);
                end
            end
        end
    end

    // New grant replaces the port's earlier binding
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bound_valid <= '0;
            for (int p = 0; p < NUM_PORTS; p++) begin
                bound_sram[p] <= '0;
            end
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (grant_valid && grant_port == port_idx_t'(p)) begin
                    bound_valid[p] <= 1'b1;
                    bound_sram[p]  <= grant_sram;
                end else if (rel_valid && rel_port == port_idx_t'(p)) begin
                    bound_valid[p] <= 1'b0;
                end
            end
        end
    end

    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        grant_valid |-> free_space[grant_sram] >= space_t'(grant_length));

    a_deq_nonempty: assert property (@(posedge clk) disable iff (!rst_n)
        deq_valid |-> pkt_count[deq_sram][deq_dest] != '0);

endmodule

`default_nettype wire

// ==== verilog/sram_write_matcher_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_write_matcher_top
    import sram_match_pkg::*;
#(
    parameter int NUM_PORTS = 4,
    parameter int NUM_SRAM  = 8
) (
    input  logic        clk,
    input  logic        rst_n,
    input  match_mode_t match_mode,
    input  logic [3:0]  match_threshold,
    input  logic        req_valid,
    output logic        req_ready,
    input  port_idx_t   req_port,
    input  port_idx_t   req_dest,
    input  pkt_len_t    req_length,
    output logic        grant_valid,
    output port_idx_t   grant_port,
    output sram_idx_t   grant_sram,
    output port_idx_t   grant_dest,
    output pkt_len_t    grant_length,
    input  logic        rel_valid,
    input  port_idx_t   rel_port,
    input  logic        deq_valid,
    input  sram_idx_t   deq_sram,
    input  port_idx_t   deq_dest,
    input  pkt_len_t    deq_length
);

    logic [NUM_PORTS-1:0] match_enable;
    port_idx_t            match_dest [NUM_PORTS];
    pkt_len_t             match_length [NUM_PORTS];
    logic [NUM_PORTS-1:0] done;
    sram_idx_t            scan_sram [NUM_PORTS];
    space_t               bank_free [NUM_PORTS];
    pkt_cnt_t             bank_count [NUM_PORTS];
    logic [NUM_PORTS-1:0] bank_accessible;
    logic [NUM_PORTS-1:0] bound_valid;
    sram_idx_t            bound_sram [NUM_PORTS];
    logic [NUM_PORTS-1:0] res_valid;
    sram_idx_t            res_sram [NUM_PORTS];
    logic [NUM_PORTS-1:0] res_ready;
    logic [NUM_PORTS-1:0] res_reject;

    wr_request_dispatch #(.NUM_PORTS(NUM_PORTS)) u_dispatch (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req_port     (req_port),
        .req_dest     (req_dest),
        .req_length   (req_length),
        .done         (done),
        .match_enable (match_enable),
        .match_dest   (match_dest),
        .match_length (match_length)
    );

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_matcher
        port_wr_sram_matcher #(.PORT_IDX(p)) u_matcher (
            .clk             (clk),
            .rst_n           (rst_n),
            .match_mode      (match_mode),
            .match_threshold (match_threshold),
            .match_enable    (match_enable[p]),
            .match_dest      (match_dest[p]),
            .match_length    (match_length[p]),
            .bank_free       (bank_free[p]),
            .bank_count      (bank_count[p]),
            .bank_accessible (bank_accessible[p]),
            .bound_valid     (bound_valid[p]),
            .bound_sram      (bound_sram[p]),
            .res_ready       (res_ready[p]),
            .res_reject      (res_reject[p]),
            .scan_sram       (scan_sram[p]),
            .res_valid       (res_valid[p]),
            .res_sram        (res_sram[p]),
            .done            (done[p])
        );
    end

    sram_alloc_arbiter #(.NUM_PORTS(NUM_PORTS)) u_arbiter (
        .clk          (clk),
        .rst_n        (rst_n),
        .res_valid    (res_valid),
        .res_sram     (res_sram),
        .match_dest   (match_dest),
        .match_length (match_length),
        .res_ready    (res_ready),
        .res_reject   (res_reject),
        .grant_valid  (grant_valid),
        .grant_port   (grant_port),
        .grant_sram   (grant_sram),
        .grant_dest   (grant_dest),
        .grant_length (grant_length)
    );

    sram_state_table #(.NUM_PORTS(NUM_PORTS), .NUM_SRAM(NUM_SRAM)) u_table (
        .clk             (clk),
        .rst_n           (rst_n),
        .scan_sram       (scan_sram),
        .scan_dest       (match_dest),
        .grant_valid     (grant_valid),
        .grant_port      (grant_port),
        .grant_sram      (grant_sram),
        .grant_dest      (grant_dest),
        .grant_length    (grant_length),
        .rel_valid       (rel_valid),
        .rel_port        (rel_port),
        .deq_valid       (deq_valid),
        .deq_sram        (deq_sram),
        .deq_dest        (deq_dest),
        .deq_length      (deq_length),
        .bank_free       (bank_free),
        .bank_count      (bank_count),
        .bank_accessible (bank_accessible),
        .bound_valid     (bound_valid),
        .bound_sram      (bound_sram)
    );

    // Static mode gives port p banks 2p and 2p+1, so the pool must be twice the ports
    a_bank_layout: assert property (@(posedge clk) NUM_SRAM == 2 * NUM_PORTS);

endmodule

`default_nettype wire

// ==== verification/tb_sram_write_matcher.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_sram_write_matcher
    import sram_match_pkg::*;
();

    localparam int BUDGET_CYCLES = 20 + 12 * 60 + 8 * 60 + 60 + 200 + 24 * 60 + 300;

    logic clk, rst_n, req_valid, req_ready, grant_valid, rel_valid, deq_valid;
    match_mode_t match_mode;
    logic [3:0]  match_threshold;
    port_idx_t   req_port, req_dest, grant_port, grant_dest, rel_port, deq_dest;
    pkt_len_t    req_length, grant_length, deq_length;
    sram_idx_t   grant_sram, deq_sram;

    int seed = 80;
    int cycle = 0;
    int errors = 0;
    int m_free [8];            // Reference model of the bank table
    int m_cnt [8][4];
    bit m_bound [4];
    int m_bsram [4];
    bit last_ok [4];           // Last consumed dest per port, for the fast path
    int last_dest [4];
    bit pending [4];           // Request sent, grant not yet seen
    bit got [4];               // Grant seen since the port's last request
    int got_sram [4], got_cyc [4], got_dest [4], got_len [4];
    int accept_cyc [4], sent_dest [4], sent_len [4];

    sram_write_matcher_top #(.NUM_PORTS(4), .NUM_SRAM(8)) UUT (
        .clk(clk), .rst_n(rst_n), .match_mode(match_mode), .match_threshold(match_threshold),
        .req_valid(req_valid), .req_ready(req_ready), .req_port(req_port),
        .req_dest(req_dest), .req_length(req_length), .grant_valid(grant_valid),
        .grant_port(grant_port), .grant_sram(grant_sram), .grant_dest(grant_dest),
        .grant_length(grant_length), .rel_valid(rel_valid), .rel_port(rel_port),
        .deq_valid(deq_valid), .deq_sram(deq_sram), .deq_dest(deq_dest), .deq_length(deq_length)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    task automatic report_mismatch(input string name, input int val, input int exp);
        $display("CHECK FAILED at %0t ns: %s = %0d, expected %0d", $time, name, val, exp);
        errors++;
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        errors++;
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input int val, input int exp);
        assert (val == exp) else report_mismatch(name, val, exp);
    endtask

    // Each observed grant updates the model the same way the table will
    always @(negedge clk) begin
        if (rst_n && grant_valid) begin
            assert (pending[grant_port])
                else report_error("grant for a port with no open request");
            assert (m_free[grant_sram] >= int'(grant_length))
                else report_error("grant on a bank without room for the packet");
            for (int q = 0; q < 4; q++) begin
                assert (q == int'(grant_port) || !(m_bound[q] && m_bsram[q] == int'(grant_sram)))
                    else report_error("grant names a bank bound to another port");
            end
            m_free[grant_sram] -= int'(grant_length);
            m_cnt[grant_sram][grant_dest] += 1;
            m_bound[grant_port] = 1'b1;
            m_bsram[grant_port] = grant_sram;
            last_ok[grant_port] = 1'b1;
            last_dest[grant_port] = grant_dest;
            pending[grant_port] = 1'b0;
            got[grant_port] = 1'b1;
            got_sram[grant_port] = grant_sram;
            got_cyc[grant_port] = cycle;
            got_dest[grant_port] = grant_dest;
            got_len[grant_port] = grant_length;
        end
    end

    // Bank the allocation rules choose for a request, -1 if none fits
    function automatic int expect_bank(input int p, input int d, input int len);
        int best, best_cnt, lo, hi;
        bit open;
        if (m_bound[p] && last_ok[p] && last_dest[p] == d && m_free[m_bsram[p]] >= len &&
            (match_mode == MODE_DYNAMIC || m_bsram[p] / 2 == p)) begin
            return m_bsram[p];
        end
        lo = (match_mode == MODE_DYNAMIC) ? 0 : 2 * p;
        hi = (match_mode == MODE_DYNAMIC) ? 7 : 2 * p + 1;
        best = -1;
        best_cnt = -1;
        for (int b = lo; b <= hi; b++) begin
            open = 1'b1;
            for (int q = 0; q < 4; q++) begin
                if (q != p && m_bound[q] && m_bsram[q] == b) open = 1'b0;
            end
            if (open && m_free[b] >= len && m_cnt[b][d] > best_cnt) begin
                best = b;                // Strictly higher count, ties stay with the first
                best_cnt = m_cnt[b][d];
            end
        end
        return best;
    endfunction

    task automatic send_req(input int p, input int d, input int len);
        int waited;
        waited = 0;
        got[p] = 1'b0;
        pending[p] = 1'b1;
        sent_dest[p] = d;
        sent_len[p] = len;
        req_port = port_idx_t'(p);
        req_dest = port_idx_t'(d);
        req_length = pkt_len_t'(len);
        req_valid = 1'b1;
        #1;
        while (!req_ready) begin
            @(negedge clk);
            #1;
            waited++;
            if (waited > 200) report_error("request never accepted");
        end
        accept_cyc[p] = cycle + 1;     // Transfer on the coming rising edge
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic wait_grant(input int p);
        int waited;
        waited = 0;
        while (!got[p]) begin
            @(negedge clk);
            #1;
            waited++;
            if (waited > 200) report_error("no grant within the timeout");
        end
        check_eq("grant_dest", got_dest[p], sent_dest[p]);
        check_eq("grant_length", got_len[p], sent_len[p]);
        @(negedge clk);
    endtask

    task automatic request_checked(input int p, input int d, input int len);
        int exp;
        exp = expect_bank(p, d, len);
        assert (exp >= 0) else report_error("test request has no bank that fits");
        send_req(p, d, len);
        wait_grant(p);
        check_eq("grant_sram", got_sram[p], exp);
    endtask

    task automatic release_port(input int p);
        @(negedge clk);
        rel_valid = 1'b1;
        rel_port = port_idx_t'(p);
        m_bound[p] = 1'b0;
        @(negedge clk);
        rel_valid = 1'b0;
    endtask

    task automatic test_reset();
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        #1;
        check_eq("req_ready", req_ready, 0);
        check_eq("grant_valid", grant_valid, 0);
        @(negedge clk);
        #1;
        check_eq("req_ready", req_ready, 1);
        @(negedge clk);
    endtask

    task automatic test_static();
        int d;
        int len;
        match_mode = MODE_STATIC;
        match_threshold = 4'd2;
        for (int p = 0; p < 4; p++) begin
            for (int n = 0; n < 3; n++) begin
                d = $unsigned($random(seed)) % 3;
                len = 1 + $unsigned($random(seed)) % 256;
                request_checked(p, d, len);
                release_port(p);         // Keeps every request on the scan path
            end
        end
    endtask

    task automatic test_dynamic();
        int len;
        match_mode = MODE_STATIC;
        while (m_free[4] >= 100) begin   // Fill bank 4 so dest 3 lands in bank 5
            len = (m_free[4] > 511) ? 511 : m_free[4];
            request_checked(2, 0, len);
        end
        request_checked(2, 3, 100);
        check_eq("grant_sram", got_sram[2], 5);
        release_port(2);
        match_mode = MODE_DYNAMIC;
        match_threshold = 4'd8;
        request_checked(0, 3, 100);
        request_checked(0, 3, 100);
        release_port(0);
        for (int b = 0; b < 8; b++) begin
            assert (b == 5 || m_cnt[b][3] < m_cnt[5][3])
                else report_error("bank 5 is not the strict maximum for dest 3");
        end
        request_checked(1, 3, 100);
        check_eq("grant_sram", got_sram[1], 5);
    endtask

    task automatic test_fast_path();
        request_checked(1, 3, 50);
        check_eq("grant_sram", got_sram[1], 5);
        check_eq("fast path latency", got_cyc[1] - accept_cyc[1], 1);
    endtask

    task automatic test_collision();
        int waited;
        waited = 0;
        release_port(1);
        send_req(2, 2, 1 + $unsigned($random(seed)) % 256);
        send_req(3, 2, 1 + $unsigned($random(seed)) % 256);
        while (!(got[2] && got[3])) begin
            @(negedge clk);
            #1;
            waited++;
            if (waited > 200) report_error("colliding requests were not both granted");
        end
        assert (got_sram[2] != got_sram[3]) else report_error("both ports granted the same bank");
        check_eq("grant_dest", got_dest[2], 2);
        check_eq("grant_dest", got_dest[3], 2);
        check_eq("grant_length", got_len[2], sent_len[2]);
        check_eq("grant_length", got_len[3], sent_len[3]);
        @(negedge clk);
    endtask

    task automatic test_exhaustion();
        int d;
        bit room;
        release_port(2);
        release_port(3);
        room = 1'b1;
        while (room) begin
            room = 1'b0;
            for (int b = 0; b < 8; b++) if (m_free[b] >= 511) room = 1'b1;
            if (room) request_checked(0, 0, 511);
        end
        send_req(0, 0, 511);
        repeat (40) begin
            @(negedge clk);
            #1;
            assert (!got[0]) else report_error("grant issued with every bank full");
        end
        @(negedge clk);
        d = 0;
        for (int q = 3; q >= 0; q--) if (m_cnt[6][q] > 0) d = q;
        deq_valid = 1'b1;                // Free one full packet in bank 6
        deq_sram = sram_idx_t'(6);
        deq_dest = port_idx_t'(d);
        deq_length = pkt_len_t'(511);
        m_free[6] += 511;
        m_cnt[6][d] -= 1;
        @(negedge clk);
        deq_valid = 1'b0;
        wait_grant(0);
        check_eq("grant_sram", got_sram[0], 6);
    endtask

    initial begin
        rst_n = 1'b0;
        req_valid = 1'b0;
        req_port = '0;
        req_dest = '0;
        req_length = '0;
        rel_valid = 1'b0;
        rel_port = '0;
        deq_valid = 1'b0;
        deq_sram = '0;
        deq_dest = '0;
        deq_length = '0;
        match_mode = MODE_STATIC;
        match_threshold = 4'd2;
        for (int b = 0; b < 8; b++) begin
            m_free[b] = SRAM_CAPACITY;
            for (int q = 0; q < 4; q++) m_cnt[b][q] = 0;
        end
        for (int p = 0; p < 4; p++) begin
            m_bound[p] = 1'b0;
            last_ok[p] = 1'b0;
            pending[p] = 1'b0;
            got[p] = 1'b0;
        end
        test_reset();
        test_static();
        test_dynamic();
        test_fast_path();
        test_collision();
        test_exhaustion();
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Ends a stuck run once the summed test budgets have run out
    initial begin
        #(BUDGET_CYCLES * 4 + 1000);
        $display("ERROR: watchdog expired before the tests completed");
        $display("Test FAILED");
        $fatal(1);
    end

endmodule

`default_nettype wire

// ==== compile.f ====
verilog/sram_match_pkg.sv
verilog/wr_request_dispatch.sv
verilog/port_wr_sram_matcher.sv
verilog/sram_alloc_arbiter.sv
verilog/sram_state_table.sv
verilog/sram_write_matcher_top.sv
verification/tb_sram_write_matcher.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the switch allocator testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_sram_write_matcher -f compile.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Test FAILED" "$LOG"; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
if ! grep -q "Test OK" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0
